/* design/box_pkg.sv */
`default_nettype none

package box_pkg;

    // ###################################################################
    // window geometry and band width
    // ###################################################################
    localparam int WIN    = 13;
    localparam int CENTER = 6;
    localparam int COLS   = 16;

    // ###################################################################
    // pipeline depth, counted in steps
    // ###################################################################
    localparam int ADD_LAT = 4;
    localparam int ACC_LAT = 1;
    localparam int OUT_LAT = ADD_LAT + ACC_LAT;

    typedef logic [7:0] pixel_t;

    // pixel 0 sits in the low byte
    typedef pixel_t [WIN-1:0] column_t;

    // 13 * 255 needs 12 bits, 169 * 255 = 43095 needs 16
    typedef logic [11:0] col_sum_t;
    typedef logic [15:0] win_sum_t;
    typedef logic [4:0]  col_idx_t;

    typedef enum logic [2:0] {
        idle,
        take,
        wait_req_low,
        present,
        wait_ack_low
    } ctrl_state_t;

endpackage

`default_nettype wire

/* design/box_step_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface box_step_if
    import box_pkg::*;
();

    // one pulse per accepted column, all pipeline registers move on it
    logic     step;
    col_idx_t band_pos;
    logic     win_valid;
    logic     result_load;

    modport ctrl (
        output step,
        output result_load,
        input  win_valid
    );

    modport count (
        input  step,
        output band_pos,
        output win_valid
    );

    modport data (
        input step,
        input result_load
    );

endinterface

`default_nettype wire

/* design/column_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module column_adder
    import box_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    i_step,
    input  wire column_t i_column,
    output col_sum_t     o_col_sum,
    output pixel_t       o_center
);

    // ###################################################################
    // adder tree registers
    // ###################################################################
    column_t          col_q;
    logic [5:0][8:0]  lvl1_q;
    logic [2:0][9:0]  lvl2_q;
    logic [1:0][10:0] lvl3_q;
    col_sum_t         sum_q;

    // row 12 has no partner in the pairwise levels and joins at level three
    pixel_t [1:0]     odd_q;

    // centre row, one register for each tree level after the input stage
    pixel_t [3:0]     ctr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            col_q  <= '0;
            lvl1_q <= '0;
            lvl2_q <= '0;
            lvl3_q <= '0;
            sum_q  <= '0;
        end else if (i_step) begin
            col_q <= i_column;
            for (int i = 0; i < 6; i++) begin
                lvl1_q[i] <= 9'(col_q[2*i]) + 9'(col_q[2*i+1]);
            end
            for (int i = 0; i < 3; i++) begin
                lvl2_q[i] <= 10'(lvl1_q[2*i]) + 10'(lvl1_q[2*i+1]);
            end
            lvl3_q[0] <= 11'(lvl2_q[0]) + 11'(lvl2_q[1]);
            lvl3_q[1] <= 11'(lvl2_q[2]) + 11'(odd_q[1]);
            sum_q     <= col_sum_t'(lvl3_q[0]) + col_sum_t'(lvl3_q[1]);
        end
    end

    // ###################################################################
    // side chains that keep pace with the tree
    // ###################################################################
    always_ff @(posedge clk) begin
        if (rst) begin
            odd_q <= '0;
            ctr_q <= '0;
        end else if (i_step) begin
            odd_q <= {odd_q[0], col_q[WIN-1]};
            ctr_q <= {ctr_q[2:0], col_q[CENTER]};
        end
    end

    // the sum and its centre pixel leave on the fourth step after acceptance
    assign o_col_sum = sum_q;
    assign o_center  = ctr_q[3];

endmodule

`default_nettype wire

/* design/local_threshold.sv */
`timescale 1ns/1ps
`default_nettype none

module local_threshold
    import box_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    box_step_if.data      bus,
    input  wire col_sum_t i_col_sum,
    input  wire pixel_t   i_center,
    output win_sum_t      o_win_sum,
    output pixel_t        o_center,
    output logic          o_bright
);

    // element 0 is the newest column
    col_sum_t [WIN-1:0]        sum_line;
    pixel_t   [WIN-CENTER-1:0] ctr_line;
    win_sum_t                  acc_q;

    // ###################################################################
    // running window sum
    // ###################################################################
    always_ff @(posedge clk) begin
        if (rst) begin
            sum_line <= '0;
            acc_q    <= '0;
        end else if (bus.step) begin
            sum_line <= {sum_line[WIN-2:0], i_col_sum};
            // modulo 2^16 arithmetic, the true window sum always fits
            acc_q    <= acc_q + win_sum_t'(i_col_sum) - win_sum_t'(sum_line[WIN-1]);
        end
    end

    // when the newest column enters, the centre column is CENTER columns older
    always_ff @(posedge clk) begin
        if (rst) begin
            ctr_line <= '0;
        end else if (bus.step) begin
            ctr_line <= {ctr_line[WIN-CENTER-2:0], i_center};
        end
    end

    // ###################################################################
    // result registers
    // ###################################################################
    always_ff @(posedge clk) begin
        if (bus.result_load) begin
            o_win_sum <= acc_q;
            o_center  <= ctr_line[WIN-CENTER-1];
            // bright when the pixel is above the mean of the window
            o_bright  <= (win_sum_t'(WIN * WIN) * win_sum_t'(ctr_line[WIN-CENTER-1]))
                         > acc_q;
        end
    end

endmodule

`default_nettype wire

/* design/column_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module column_counter
    import box_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    box_step_if.count bus
);

    // counts the first OUT_LAT steps, whose columns never reach the accumulator
    logic [2:0] fill_cnt;
    logic       lag_run;
    col_idx_t   lag_pos;

    logic       run_nxt;
    col_idx_t   lag_nxt;

    // band position of the column that the accumulator takes on this step
    always_comb begin
        run_nxt = lag_run;
        lag_nxt = lag_pos;
        if (lag_run) begin
            lag_nxt = (lag_pos == col_idx_t'(COLS - 1)) ? '0 : lag_pos + 1'b1;
        end else if (fill_cnt == 3'(OUT_LAT)) begin
            run_nxt = 1'b1;
            lag_nxt = '0;
        end
    end

    // a full window of one band ends at positions WIN-1 up to COLS-1
    assign bus.win_valid = run_nxt && (lag_nxt >= col_idx_t'(WIN - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.band_pos <= '0;
            fill_cnt     <= '0;
            lag_run      <= 1'b0;
            lag_pos      <= '0;
        end else if (bus.step) begin
            bus.band_pos <= (bus.band_pos == col_idx_t'(COLS - 1)) ? '0 : bus.band_pos + 1'b1;
            lag_run      <= run_nxt;
            lag_pos      <= lag_nxt;
            if (!lag_run && fill_cnt != 3'(OUT_LAT)) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    a_lag_range: assert property (@(posedge clk) disable iff (rst)
        lag_pos < col_idx_t'(COLS));

    // the lagging position trails the accepted column by exactly OUT_LAT
    a_lag_align: assert property (@(posedge clk) disable iff (rst)
        bus.step && run_nxt |->
            lag_nxt == col_idx_t'((bus.band_pos + COLS - OUT_LAT) % COLS));

endmodule

`default_nettype wire

/* design/box_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module box_ctrl
    import box_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic i_in_req,
    output logic      o_in_ack,
    output logic      o_out_req,
    input  wire logic i_out_ack,
    box_step_if.ctrl  bus
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        load_q;

    // ###################################################################
    // handshake state machine
    // ###################################################################
    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (i_in_req) begin
                    state_nxt = take;
                end
            end
            take: begin
                state_nxt = bus.win_valid ? present : wait_req_low;
            end
            present: begin
                if (o_out_req && i_out_ack) begin
                    state_nxt = wait_ack_low;
                end
            end
            wait_ack_low: begin
                if (!i_out_ack) begin
                    state_nxt = wait_req_low;
                end
            end
            wait_req_low: begin
                if (!i_in_req) begin
                    state_nxt = idle;
                end
            end
            default: state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            o_in_ack  <= 1'b0;
            o_out_req <= 1'b0;
            load_q    <= 1'b0;
        end else begin
            state  <= state_nxt;
            load_q <= (state == take) && bus.win_valid;
            case (state)
                // without a result the column is acknowledged at once
                take:         o_in_ack  <= !bus.win_valid;
                present:      o_out_req <= !(o_out_req && i_out_ack);
                // a pending result holds back the input ack
                wait_ack_low: o_in_ack  <= !i_out_ack;
                wait_req_low: o_in_ack  <= i_in_req;
                default:      o_in_ack  <= o_in_ack;
            endcase
        end
    end

    assign bus.step        = (state == take);
    assign bus.result_load = load_q;

    a_step_single: assert property (@(posedge clk) disable iff (rst)
        bus.step |=> !bus.step);

    a_out_req_hold: assert property (@(posedge clk) disable iff (rst)
        o_out_req && !i_out_ack |=> o_out_req);

endmodule

`default_nettype wire

/* design/box_filter_top.sv */
`timescale 1ns/1ps
`default_nettype none

module box_filter_top
    import box_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    i_in_req,
    input  wire column_t i_column,
    output logic         o_in_ack,
    output logic         o_out_req,
    input  wire logic    i_out_ack,
    output win_sum_t     o_win_sum,
    output pixel_t       o_center,
    output logic         o_bright
);

    col_sum_t col_sum;
    pixel_t   col_center;

    box_step_if u_step_if ();

    box_ctrl u_box_ctrl (
        .clk       (clk),
        .rst       (rst),
        .i_in_req  (i_in_req),
        .o_in_ack  (o_in_ack),
        .o_out_req (o_out_req),
        .i_out_ack (i_out_ack),
        .bus       (u_step_if.ctrl)
    );

    column_counter u_column_counter (
        .clk (clk),
        .rst (rst),
        .bus (u_step_if.count)
    );

    column_adder u_column_adder (
        .clk       (clk),
        .rst       (rst),
        .i_step    (u_step_if.step),
        .i_column  (i_column),
        .o_col_sum (col_sum),
        .o_center  (col_center)
    );

    local_threshold u_local_threshold (
        .clk       (clk),
        .rst       (rst),
        .bus       (u_step_if.data),
        .i_col_sum (col_sum),
        .i_center  (col_center),
        .o_win_sum (o_win_sum),
        .o_center  (o_center),
        .o_bright  (o_bright)
    );

endmodule

`default_nettype wire

/* tb/box_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module box_checker
    import box_pkg::*;
#(
    parameter int MAX_RESULTS = 64
)(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     i_in_req,
    input  wire logic     i_in_ack,
    input  wire logic     i_out_req,
    input  wire logic     i_out_ack,
    input  wire win_sum_t i_win_sum,
    input  wire pixel_t   i_center,
    input  wire logic     i_bright,
    input  var  win_sum_t i_exp_sum [MAX_RESULTS],
    input  var  pixel_t   i_exp_center [MAX_RESULTS],
    input  var  logic     i_exp_bright [MAX_RESULTS],
    input  var  int       i_exp_count,
    output int            o_checked,
    output int            o_errors
);

    logic in_req_q;
    logic in_ack_q;
    logic out_req_q;
    logic out_ack_q;

    // compares one result against the next expectation in emission order
    task automatic compare_result();
        string name;
        string exp_str;
        string act_str;
        int    idx;
        idx  = o_checked;
        name = $sformatf("result_%0d", idx);
        if (idx >= i_exp_count) begin
            $display("unexpected extra result number %0d, sum %0d centre %0d",
                     idx, i_win_sum, i_center);
            o_errors = o_errors + 1;
        end else if (i_win_sum != i_exp_sum[idx] || i_center != i_exp_center[idx]
                     || i_bright != i_exp_bright[idx]) begin
            exp_str = $sformatf("sum %0d centre %0d bright %0d",
                                i_exp_sum[idx], i_exp_center[idx], i_exp_bright[idx]);
            act_str = $sformatf("sum %0d centre %0d bright %0d",
                                i_win_sum, i_center, i_bright);
            $display("FAIL %s: expected %s, actual %s", name, exp_str, act_str);
            o_errors = o_errors + 1;
        end else begin
            $display("ok   %s: sum %0d centre %0d bright %0d",
                     name, i_win_sum, i_center, i_bright);
        end
        o_checked = o_checked + 1;
    endtask

    // ####################################################################
    // handshake rules and result sampling
    // ####################################################################
    always @(posedge clk) begin
        if (rst) begin
            in_req_q  = 1'b0;
            in_ack_q  = 1'b0;
            out_req_q = 1'b0;
            out_ack_q = 1'b0;
            o_checked = 0;
            o_errors  = 0;
        end else begin
            // an edge seen now was made by the DUT on the previous clock,
            // so it is judged against the partner signal of that clock
            if (i_in_ack && !in_ack_q && !in_req_q) begin
                $display("input ack rose while the input request was low");
                o_errors = o_errors + 1;
            end
            if (!i_in_ack && in_ack_q && in_req_q) begin
                $display("input ack fell while the input request was still high");
                o_errors = o_errors + 1;
            end
            if (!i_out_req && out_req_q && !out_ack_q) begin
                $display("output request fell before the sink acknowledged it");
                o_errors = o_errors + 1;
            end
            if (i_in_ack && (i_out_req || i_out_ack)) begin
                $display("input ack was high while a result handshake was still open");
                o_errors = o_errors + 1;
            end
            // the result registers load on the same edge that raises the request
            if (i_out_req && !out_req_q) begin
                compare_result();
            end
            in_req_q  = i_in_req;
            in_ack_q  = i_in_ack;
            out_req_q = i_out_req;
            out_ack_q = i_out_ack;
        end
    end

endmodule

`default_nettype wire

/* tb/tb_box_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_box_filter
    import box_pkg::*;
();

    localparam int          MAX_RESULTS = 64;
    localparam logic [31:0] SEED        = 32'h693bfa22;

    logic     clk;
    logic     rst;
    logic     i_in_req;
    column_t  i_column;
    logic     o_in_ack;
    logic     o_out_req;
    logic     i_out_ack;
    win_sum_t o_win_sum;
    pixel_t   o_center;
    logic     o_bright;

    column_t     columns [$];
    win_sum_t    exp_sum [MAX_RESULTS];
    pixel_t      exp_center [MAX_RESULTS];
    logic        exp_bright [MAX_RESULTS];
    int          exp_count;
    int          checked;
    int          errors;
    int          setup_errors;
    int          cycles;
    int          limit;
    logic [31:0] in_lfsr;
    logic [31:0] out_lfsr;

    box_filter_top u_box_filter_top (
        .clk       (clk),
        .rst       (rst),
        .i_in_req  (i_in_req),
        .i_column  (i_column),
        .o_in_ack  (o_in_ack),
        .o_out_req (o_out_req),
        .i_out_ack (i_out_ack),
        .o_win_sum (o_win_sum),
        .o_center  (o_center),
        .o_bright  (o_bright)
    );

    box_checker #(.MAX_RESULTS(MAX_RESULTS)) u_box_checker (
        .clk          (clk),
        .rst          (rst),
        .i_in_req     (i_in_req),
        .i_in_ack     (o_in_ack),
        .i_out_req    (o_out_req),
        .i_out_ack    (i_out_ack),
        .i_win_sum    (o_win_sum),
        .i_center     (o_center),
        .i_bright     (o_bright),
        .i_exp_sum    (exp_sum),
        .i_exp_center (exp_center),
        .i_exp_bright (exp_bright),
        .i_exp_count  (exp_count),
        .o_checked    (checked),
        .o_errors     (errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // fibonacci lfsr with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_next(state);
            value = (value << 1) | int'(state[0]);
        end
    endtask

    // ####################################################################
    // golden file, C lines are input columns and E lines expected results
    // ####################################################################
    task automatic read_golden();
        int      fd;
        int      n;
        int      s;
        int      c;
        int      b;
        int      p [WIN];
        string   line;
        column_t col;
        exp_count = 0;
        for (int i = 0; i < MAX_RESULTS; i++) begin
            exp_sum[i]    = '0;
            exp_center[i] = '0;
            exp_bright[i] = 1'b0;
        end
        fd = $fopen("tb/box_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file tb/box_golden.txt");
            setup_errors = setup_errors + 1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line[0] == "C") begin
                    n = $sscanf(line, "C %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                p[0], p[1], p[2], p[3], p[4], p[5], p[6],
                                p[7], p[8], p[9], p[10], p[11], p[12]);
                    if (n != WIN) begin
                        $display("malformed column line in the golden file");
                        setup_errors = setup_errors + 1;
                    end
                    for (int r = 0; r < WIN; r++) begin
                        col[r] = pixel_t'(p[r]);
                    end
                    columns.push_back(col);
                end else if (n > 0 && line.len() > 0 && line[0] == "E") begin
                    n = $sscanf(line, "E %h %h %h", s, c, b);
                    if (n != 3 || exp_count >= MAX_RESULTS) begin
                        $display("malformed or surplus expectation line in the golden file");
                        setup_errors = setup_errors + 1;
                    end else begin
                        exp_sum[exp_count]    = win_sum_t'(s);
                        exp_center[exp_count] = pixel_t'(c);
                        exp_bright[exp_count] = (b != 0);
                        exp_count = exp_count + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_column(input column_t col);
        int gap;
        draw_bits(in_lfsr, 2, gap);
        repeat (gap) @(negedge clk);
        i_column = col;
        i_in_req = 1'b1;
        do @(negedge clk); while (!o_in_ack);
        i_in_req = 1'b0;
        do @(negedge clk); while (o_in_ack);
    endtask

    // every third result is acknowledged slowly to stall the input side
    initial begin
        int gap;
        int acks;
        acks      = 0;
        i_out_ack = 1'b0;
        forever begin
            do @(negedge clk); while (o_out_req !== 1'b1);
            draw_bits(out_lfsr, 2, gap);
            if (acks % 3 == 2) begin
                gap = gap + 6;
            end
            repeat (gap) @(negedge clk);
            i_out_ack = 1'b1;
            do @(negedge clk); while (o_out_req);
            i_out_ack = 1'b0;
            acks = acks + 1;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("results seen %0d of %0d, the missing ones never arrived",
                     checked, exp_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        rst          = 1'b1;
        i_in_req     = 1'b0;
        i_column     = '0;
        cycles       = 0;
        limit        = 0;
        setup_errors = 0;
        in_lfsr      = SEED;
        out_lfsr     = SEED;
        read_golden();
        limit = columns.size() * 20 + 100;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        if (o_in_ack !== 1'b0 || o_out_req !== 1'b0) begin
            $display("handshake outputs are not low after reset");
            setup_errors = setup_errors + 1;
        end
        foreach (columns[i]) begin
            send_column(columns[i]);
        end
        while (checked < exp_count) @(negedge clk);
        // a quiet stretch so that a surplus result would still be seen
        repeat (40) @(negedge clk);
        $display("results checked %0d of %0d, errors %0d",
                 checked, exp_count, errors + setup_errors);
        if (errors + setup_errors == 0 && checked == exp_count) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
design/box_pkg.sv
design/box_step_if.sv
design/column_adder.sv
design/local_threshold.sv
design/column_counter.sv
design/box_ctrl.sv
design/box_filter_top.sv
tb/box_checker.sv
tb/tb_box_filter.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_box_filter \
    -Mdir obj_dir

./obj_dir/Vtb_box_filter 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failures"
exit 0

/* tb/box_golden.txt */
# C p0 .. p12 : one input column in hex, pixel 0 first
# E sum centre bright : expected result in hex, in emission order
C ff ff ff ff ff ff ff ff ff ff ff ff ff
C ff ff ff ff ff ff ff ff ff ff ff ff ff
C ff ff ff ff ff ff ff ff ff ff ff ff ff
C ff ff ff ff ff ff ff ff ff ff ff ff ff
C ff ff ff ff ff ff ff ff ff ff ff ff ff
C ff ff ff ff ff ff ff ff ff ff ff ff ff
C ff ff ff ff ff ff ff ff ff ff ff ff ff
C ff ff ff ff ff ff ff ff ff ff ff ff ff
C ff ff ff ff ff ff ff ff ff ff ff ff ff
C ff ff ff ff ff ff ff ff ff ff ff ff ff
C ff ff ff ff ff ff ff ff ff ff ff ff ff
C ff ff ff ff ff ff ff ff ff ff ff ff ff
C ff ff ff ff ff ff ff ff ff ff ff ff ff
C ff ff ff ff ff ff ff ff ff ff ff ff ff
C ff ff ff ff ff ff ff ff ff ff ff ff ff
C ff ff ff ff ff ff ff ff ff ff ff ff ff
E a857 ff 0
E a857 ff 0
E a857 ff 0
E a857 ff 0
C 64 64 64 64 64 64 64 64 64 64 64 64 64
C 64 64 64 64 64 64 64 64 64 64 64 64 64
C 64 64 64 64 64 64 64 64 64 64 64 64 64
C 64 64 64 64 64 64 64 64 64 64 64 64 64
C 64 64 64 64 64 64 64 64 64 64 64 64 64
C 64 64 64 64 64 64 64 64 64 64 64 64 64
C 64 64 64 64 64 64 65 64 64 64 64 64 64
C 64 64 64 64 64 64 63 64 64 64 64 64 64
C 64 64 64 64 64 64 65 64 64 64 64 64 64
C 64 64 64 64 64 64 63 64 64 64 64 64 64
C 64 64 64 64 64 64 64 64 64 64 64 64 64
C 64 64 64 64 64 64 64 64 64 64 64 64 64
C 64 64 64 64 64 64 64 64 64 64 64 64 64
C 64 64 64 64 64 64 64 64 64 64 64 64 64
C 64 64 64 64 64 64 64 64 64 64 64 64 64
C 64 64 64 64 64 64 64 64 64 64 64 64 64
E 4204 65 1
E 4204 63 0
E 4204 65 1
E 4204 63 0
C 00 01 02 03 04 05 06 07 08 09 0a 0b 0c
C 10 11 12 13 14 15 16 17 18 19 1a 1b 1c
C 20 21 22 23 24 25 26 27 28 29 2a 2b 2c
C 30 31 32 33 34 35 36 37 38 39 3a 3b 3c
C 40 41 42 43 44 45 46 47 48 49 4a 4b 4c
C 50 51 52 53 54 55 56 57 58 59 5a 5b 5c
C 60 61 62 63 64 65 66 67 68 69 6a 6b 6c
C 70 71 72 73 74 75 76 77 78 79 7a 7b 7c
C 80 81 82 83 84 85 86 87 88 89 8a 8b 8c
C 90 91 92 93 94 95 97 97 98 99 9a 9b 9c
C a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac
C b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 ba bb bc
C c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb cc
C d0 d1 d2 d3 d4 d5 d6 d7 d8 d9 da db dc
C e0 e1 e2 e3 e4 e5 e6 e7 e8 e9 ea eb ec
C f0 f1 f2 f3 f4 f5 f6 f7 f8 f9 fa fb fc
E 4357 66 0
E 4de7 76 0
E 5877 86 0
E 6307 97 1
C 00 00 00 00 00 00 00 00 00 00 00 00 00
C 00 00 00 00 00 00 00 00 00 00 00 00 00
C 00 00 00 00 00 00 00 00 00 00 00 00 00
C 00 00 00 00 00 00 00 00 00 00 00 00 00
C 00 00 00 00 00 00 00 00 00 00 00 00 00
